//--- mtimer_pkg.sv
package mtimer_pkg;

  // Register offset inside the timer window
  typedef logic [15:0] addr_t;

  typedef logic [31:0] data_t;

  typedef logic [3:0] id_t;

  typedef logic [1:0] resp_t;

  // mtime and mtimecmp
  typedef logic [63:0] time_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  localparam addr_t OFS_MTIME_LO = 16'h0000;
  localparam addr_t OFS_MTIME_HI = 16'h0004;
  localparam addr_t OFS_CMP_LO   = 16'h0008;
  localparam addr_t OFS_CMP_HI   = 16'h000C;

  // Target of a decoded access, SEL_NONE for unmapped offsets
  typedef enum logic [2:0] {
    SEL_MTIME_LO,
    SEL_MTIME_HI,
    SEL_CMP_LO,
    SEL_CMP_HI,
    SEL_NONE
  } reg_sel_t;

endpackage

//--- mtimer_prescaler.sv
module mtimer_prescaler #(
  parameter int PRESCALE = 1
) (
  input  logic clk,
  input  logic rst,
  output logic tick
);

  localparam int CW = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;
  localparam logic [CW-1:0] RELOAD = CW'(PRESCALE - 1);

  logic [CW-1:0] cnt;

  // Down-counter, tick on wrap
  always_ff @(posedge clk) begin
    if (!rst) begin
      cnt  <= RELOAD;
      tick <= 1'b0;
    end else if (cnt == '0) begin
      cnt  <= RELOAD;
      tick <= 1'b1;
    end else begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

  // Back-to-back ticks only when dividing by one
  a_tick_spacing: assert property (
    @(posedge clk) disable iff (!rst)
    (PRESCALE > 1) && tick |=> !tick
  ) else $error("prescaler tick high on two consecutive cycles");

endmodule

//--- mtimer_axi_slave.sv
module mtimer_axi_slave (
  input  logic                 clk,
  input  logic                 rst,

  input  logic                 awvalid,
  output logic                 awready,
  input  mtimer_pkg::addr_t    awaddr,
  input  mtimer_pkg::id_t      awid,

  input  logic                 wvalid,
  output logic                 wready,
  input  mtimer_pkg::data_t    wdata,

  output logic                 bvalid,
  input  logic                 bready,
  output mtimer_pkg::resp_t    bresp,
  output mtimer_pkg::id_t      bid,

  input  logic                 arvalid,
  output logic                 arready,
  input  mtimer_pkg::addr_t    araddr,
  input  mtimer_pkg::id_t      arid,

  output logic                 rvalid,
  input  logic                 rready,
  output mtimer_pkg::data_t    rdata,
  output mtimer_pkg::resp_t    rresp,
  output mtimer_pkg::id_t      rid,
  output logic                 rlast,

  output logic                 wr_en,
  output mtimer_pkg::reg_sel_t wr_sel,
  output mtimer_pkg::data_t    wr_data,
  output mtimer_pkg::reg_sel_t rd_sel,
  input  mtimer_pkg::data_t    rd_data
);

  typedef enum logic [1:0] {
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_t;

  wr_state_t            wr_state;
  mtimer_pkg::reg_sel_t wr_sel_q;
  logic                 aw_fire;
  logic                 w_fire;
  logic                 ar_fire;

  function automatic mtimer_pkg::reg_sel_t decode(input mtimer_pkg::addr_t addr);
    case (addr)
      mtimer_pkg::OFS_MTIME_LO: decode = mtimer_pkg::SEL_MTIME_LO;
      mtimer_pkg::OFS_MTIME_HI: decode = mtimer_pkg::SEL_MTIME_HI;
      mtimer_pkg::OFS_CMP_LO:   decode = mtimer_pkg::SEL_CMP_LO;
      mtimer_pkg::OFS_CMP_HI:   decode = mtimer_pkg::SEL_CMP_HI;
      default:                  decode = mtimer_pkg::SEL_NONE;
    endcase
  endfunction

  assign awready = (wr_state == WR_ADDR);
  assign wready  = (wr_state == WR_DATA);
  assign bvalid  = (wr_state == WR_RESP);

  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // Unmapped writes are dropped
  assign wr_en   = w_fire && (wr_sel_q != mtimer_pkg::SEL_NONE);
  assign wr_sel  = wr_sel_q;
  assign wr_data = wdata;

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_state <= WR_ADDR;
    end else begin
      case (wr_state)
        WR_ADDR: if (aw_fire) wr_state <= WR_DATA;
        WR_DATA: if (w_fire) wr_state <= WR_RESP;
        WR_RESP: if (bready) wr_state <= WR_ADDR;
        default: wr_state <= WR_ADDR;
      endcase
    end
  end

  // Write address and response payload
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_sel_q <= decode(awaddr);
      bid      <= awid;
    end
    if (w_fire) begin
      bresp <= (wr_sel_q == mtimer_pkg::SEL_NONE) ? mtimer_pkg::RESP_SLVERR
                                                  : mtimer_pkg::RESP_OKAY;
    end
  end

  // One read response in flight
  assign arready = !rvalid;
  assign ar_fire = arvalid && arready;
  assign rd_sel  = decode(araddr);
  assign rlast   = rvalid;

  always_ff @(posedge clk) begin
    if (!rst) begin
      rvalid <= 1'b0;
    end else if (ar_fire) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      rdata <= rd_data;
      rresp <= (rd_sel == mtimer_pkg::SEL_NONE) ? mtimer_pkg::RESP_SLVERR
                                                : mtimer_pkg::RESP_OKAY;
      rid   <= arid;
    end
  end

  a_bvalid_hold: assert property (
    @(posedge clk) disable iff (!rst)
    bvalid && !bready |=> bvalid
  ) else $error("bvalid dropped before bready");

  a_rdata_stable: assert property (
    @(posedge clk) disable iff (!rst)
    rvalid && !rready |=> rvalid && $stable(rdata)
  ) else $error("read response changed while stalled");

endmodule

//--- mtimer_regs.sv
module mtimer_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 tick,
  input  logic                 wr_en,
  input  mtimer_pkg::reg_sel_t wr_sel,
  input  mtimer_pkg::data_t    wr_data,
  input  mtimer_pkg::reg_sel_t rd_sel,
  output mtimer_pkg::data_t    rd_data,
  output logic                 irq
);

  mtimer_pkg::time_t mtime;
  mtimer_pkg::time_t mtimecmp;
  logic              mtime_wr;

  assign mtime_wr = wr_en && ((wr_sel == mtimer_pkg::SEL_MTIME_LO) ||
                              (wr_sel == mtimer_pkg::SEL_MTIME_HI));

  // Software write beats the tick
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime <= '0;
    end else if (mtime_wr) begin
      if (wr_sel == mtimer_pkg::SEL_MTIME_LO) begin
        mtime[31:0] <= wr_data;
      end else begin
        mtime[63:32] <= wr_data;
      end
    end else if (tick) begin
      mtime <= mtime + 64'd1;
    end
  end

  // All ones so no interrupt fires out of reset
  always_ff @(posedge clk) begin
    if (!rst) begin
      mtimecmp <= '1;
    end else if (wr_en) begin
      case (wr_sel)
        mtimer_pkg::SEL_CMP_LO: mtimecmp[31:0]  <= wr_data;
        mtimer_pkg::SEL_CMP_HI: mtimecmp[63:32] <= wr_data;
        default: ;
      endcase
    end
  end

  always_comb begin
    case (rd_sel)
      mtimer_pkg::SEL_MTIME_LO: rd_data = mtime[31:0];
      mtimer_pkg::SEL_MTIME_HI: rd_data = mtime[63:32];
      mtimer_pkg::SEL_CMP_LO:   rd_data = mtimecmp[31:0];
      mtimer_pkg::SEL_CMP_HI:   rd_data = mtimecmp[63:32];
      default:                  rd_data = '0;
    endcase
  end

  // Compare stage
  always_ff @(posedge clk) begin
    if (!rst) begin
      irq <= 1'b0;
    end else begin
      irq <= (mtime >= mtimecmp);
    end
  end

  a_irq_reset: assert property (
    @(posedge clk)
    $rose(rst) |=> !irq
  ) else $error("irq high right after reset");

endmodule

//--- mtimer_top.sv
module mtimer_top #(
  parameter int PRESCALE = 1
) (
  input  logic              clk,
  input  logic              rst,

  input  logic              awvalid,
  output logic              awready,
  input  mtimer_pkg::addr_t awaddr,
  input  mtimer_pkg::id_t   awid,

  input  logic              wvalid,
  output logic              wready,
  input  mtimer_pkg::data_t wdata,

  output logic              bvalid,
  input  logic              bready,
  output mtimer_pkg::resp_t bresp,
  output mtimer_pkg::id_t   bid,

  input  logic              arvalid,
  output logic              arready,
  input  mtimer_pkg::addr_t araddr,
  input  mtimer_pkg::id_t   arid,

  output logic              rvalid,
  input  logic              rready,
  output mtimer_pkg::data_t rdata,
  output mtimer_pkg::resp_t rresp,
  output mtimer_pkg::id_t   rid,
  output logic              rlast,

  output logic              irq
);

  logic                 tick;
  logic                 wr_en;
  mtimer_pkg::reg_sel_t wr_sel;
  mtimer_pkg::data_t    wr_data;
  mtimer_pkg::reg_sel_t rd_sel;
  mtimer_pkg::data_t    rd_data;

  mtimer_prescaler #(
    .PRESCALE (PRESCALE)
  ) prescaler_i (
    .clk  (clk),
    .rst  (rst),
    .tick (tick)
  );

  mtimer_axi_slave axi_slave_i (
    .clk     (clk),
    .rst     (rst),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .awid    (awid),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bvalid  (bvalid),
    .bready  (bready),
    .bresp   (bresp),
    .bid     (bid),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr),
    .arid    (arid),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rid     (rid),
    .rlast   (rlast),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .rd_sel  (rd_sel),
    .rd_data (rd_data)
  );

  mtimer_regs regs_i (
    .clk     (clk),
    .rst     (rst),
    .tick    (tick),
    .wr_en   (wr_en),
    .wr_sel  (wr_sel),
    .wr_data (wr_data),
    .rd_sel  (rd_sel),
    .rd_data (rd_data),
    .irq     (irq)
  );

endmodule

//--- tb_mtimer_top.sv
module tb_mtimer_top;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic RD = 1'b0;
  localparam logic WR = 1'b1;
  localparam mtimer_pkg::resp_t OK  = mtimer_pkg::RESP_OKAY;
  localparam mtimer_pkg::resp_t ERR = mtimer_pkg::RESP_SLVERR;

  // One bus access, nonzero tol marks a read of the running counter
  typedef struct packed {
    logic              op;
    mtimer_pkg::addr_t addr;
    mtimer_pkg::id_t   id;
    mtimer_pkg::data_t wdata;
    mtimer_pkg::resp_t resp;
    mtimer_pkg::data_t rdata;
    mtimer_pkg::data_t tol;
  } row_t;

  logic clk;
  logic rst;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast, irq;
  mtimer_pkg::addr_t awaddr, araddr;
  mtimer_pkg::id_t   awid, bid, arid, rid;
  mtimer_pkg::data_t wdata, rdata;
  mtimer_pkg::resp_t bresp, rresp;

  int unsigned cycle = 0;
  int unsigned w_cycle;
  int unsigned ar_cycle;

  row_t rows [15] = '{
    // Reset values
    '{RD, 16'h0008, 4'h1, 32'h0, OK, 32'hFFFF_FFFF, 32'd0},
    '{RD, 16'h000C, 4'h2, 32'h0, OK, 32'hFFFF_FFFF, 32'd0},
    // mtimecmp roundtrip
    '{WR, 16'h0008, 4'h3, 32'h1234_5678, OK, 32'h0, 32'd0},
    '{WR, 16'h000C, 4'h4, 32'h0000_ABCD, OK, 32'h0, 32'd0},
    '{RD, 16'h0008, 4'h5, 32'h0, OK, 32'h1234_5678, 32'd0},
    '{RD, 16'h000C, 4'h6, 32'h0, OK, 32'h0000_ABCD, 32'd0},
    // Unmapped offsets
    '{WR, 16'h0010, 4'h7, 32'hDEAD_BEEF, ERR, 32'h0, 32'd0},
    '{RD, 16'h0014, 4'h8, 32'h0, ERR, 32'h0, 32'd0},
    '{RD, 16'h0008, 4'h9, 32'h0, OK, 32'h1234_5678, 32'd0},
    '{RD, 16'h000C, 4'hA, 32'h0, OK, 32'h0000_ABCD, 32'd0},
    // Counting from zero
    '{WR, 16'h0004, 4'hB, 32'h0, OK, 32'h0, 32'd0},
    '{WR, 16'h0000, 4'hC, 32'h0, OK, 32'h0, 32'd0},
    '{RD, 16'h0000, 4'hD, 32'h0, OK, 32'h0, 32'd1},
    '{RD, 16'h0000, 4'hE, 32'h0, OK, 32'h0, 32'd1},
    '{RD, 16'h0004, 4'hF, 32'h0, OK, 32'h0, 32'd0}
  };

  mtimer_top #(.PRESCALE(4)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "run stopped at first failure");
  endtask

  function automatic logic level(input string name);
    if (name == "awready") return awready;
    if (name == "wready") return wready;
    if (name == "bvalid") return bvalid;
    if (name == "arready") return arready;
    if (name == "rvalid") return rvalid;
    return irq;
  endfunction

  // Poll at the falling edge until the named signal is high
  task automatic wait_high(input string name, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!level(name)) begin
      n++;
      if (n >= limit) begin
        $display("Timeout: %s stayed low for %0d cycles", name, limit);
        stop_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic check_data(input string name, input mtimer_pkg::data_t got,
                            input mtimer_pkg::data_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_resp(input string name, input mtimer_pkg::resp_t got,
                            input mtimer_pkg::resp_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_id(input string name, input mtimer_pkg::id_t got,
                          input mtimer_pkg::id_t exp);
    if (got !== exp) begin
      $display("** Error: %s = %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: irq = %h, expected %h", got, exp);
      stop_run();
    end
  endtask

  task automatic check_count(input mtimer_pkg::data_t got, input mtimer_pkg::data_t lo,
                             input mtimer_pkg::data_t hi);
    if (got < lo || got > hi) begin
      $display("** Error: rdata = %h, expected %h to %h", got, lo, hi);
      stop_run();
    end
  endtask

  task automatic axi_write(input mtimer_pkg::addr_t addr, input mtimer_pkg::id_t id,
                           input mtimer_pkg::data_t data, input int unsigned stall,
                           output mtimer_pkg::resp_t resp,
                           output mtimer_pkg::id_t resp_id);
    @(posedge clk);
    awvalid <= 1'b1;
    awaddr  <= addr;
    awid    <= id;
    wvalid  <= 1'b1;
    wdata   <= data;
    wait_high("awready", 50);
    @(posedge clk);
    awvalid <= 1'b0;
    wait_high("wready", 50);
    w_cycle = cycle;
    @(posedge clk);
    wvalid <= 1'b0;
    wait_high("bvalid", 50);
    resp    = bresp;
    resp_id = bid;
    repeat (stall) begin
      @(negedge clk);
      if (!bvalid) begin
        $display("bvalid dropped while bready was held low");
        stop_run();
      end
    end
    @(posedge clk);
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input mtimer_pkg::addr_t addr, input mtimer_pkg::id_t id,
                          input int unsigned stall, output mtimer_pkg::data_t data,
                          output mtimer_pkg::resp_t resp,
                          output mtimer_pkg::id_t resp_id, output logic last);
    @(posedge clk);
    arvalid <= 1'b1;
    araddr  <= addr;
    arid    <= id;
    wait_high("arready", 50);
    ar_cycle = cycle;
    @(posedge clk);
    arvalid <= 1'b0;
    wait_high("rvalid", 50);
    data    = rdata;
    resp    = rresp;
    resp_id = rid;
    last    = rlast;
    // Response must hold still while rready is low
    repeat (stall) begin
      @(negedge clk);
      if (!rvalid) begin
        $display("rvalid dropped while rready was held low");
        stop_run();
      end
      check_data("rdata", rdata, data);
    end
    @(posedge clk);
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  initial begin
    mtimer_pkg::resp_t resp;
    mtimer_pkg::id_t   resp_id;
    mtimer_pkg::data_t data;
    mtimer_pkg::data_t prev;
    logic              last;
    logic              have_prev;
    int unsigned       set_cycle;

    void'($urandom(32'h99b8));
    rst       = 1'b0;
    awvalid   = 1'b0;
    awaddr    = '0;
    awid      = '0;
    wvalid    = 1'b0;
    wdata     = '0;
    bready    = 1'b0;
    arvalid   = 1'b0;
    araddr    = '0;
    arid      = '0;
    rready    = 1'b0;
    have_prev = 1'b0;
    prev      = '0;
    set_cycle = 0;
    repeat (8) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_irq(irq, 1'b0);

    foreach (rows[i]) begin
      if (rows[i].op == WR) begin
        axi_write(rows[i].addr, rows[i].id, rows[i].wdata, $urandom_range(8, 1),
                  resp, resp_id);
        check_resp("bresp", resp, rows[i].resp);
        check_id("bid", resp_id, rows[i].id);
        if (rows[i].addr == mtimer_pkg::OFS_MTIME_LO) begin
          set_cycle = w_cycle;
          have_prev = 1'b0;
        end
      end else begin
        axi_read(rows[i].addr, rows[i].id, $urandom_range(8, 1), data, resp, resp_id, last);
        check_resp("rresp", resp, rows[i].resp);
        check_id("rid", resp_id, rows[i].id);
        if (last !== 1'b1) begin
          $display("** Error: rlast = %h, expected 1", last);
          stop_run();
        end
        if (rows[i].tol == '0) begin
          check_data("rdata", data, rows[i].rdata);
        end else begin
          // At most one tick per 4 cycles since the write, and always moving up
          check_count(data, have_prev ? prev + 1 : rows[i].rdata,
                      rows[i].rdata + (ar_cycle - set_cycle) / 4 + rows[i].tol);
          prev      = data;
          have_prev = 1'b1;
        end
      end
    end

    // Interrupt once mtime reaches 40 ticks
    axi_write(mtimer_pkg::OFS_MTIME_HI, 4'h1, 32'h0, 0, resp, resp_id);
    axi_write(mtimer_pkg::OFS_MTIME_LO, 4'h2, 32'h0, 0, resp, resp_id);
    axi_write(mtimer_pkg::OFS_CMP_HI, 4'h3, 32'h0, 0, resp, resp_id);
    axi_write(mtimer_pkg::OFS_CMP_LO, 4'h4, 32'd40, 0, resp, resp_id);
    check_resp("bresp", resp, OK);
    axi_read(mtimer_pkg::OFS_CMP_LO, 4'h5, 0, data, resp, resp_id, last);
    check_data("rdata", data, 32'd40);
    check_irq(irq, 1'b0);
    wait_high("irq", 200);
    axi_write(mtimer_pkg::OFS_CMP_HI, 4'h6, 32'hFFFF_FFFF, 0, resp, resp_id);
    @(negedge clk);
    check_irq(irq, 1'b0);

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- mtimer_top.f
mtimer_pkg.sv
mtimer_prescaler.sv
mtimer_axi_slave.sv
mtimer_regs.sv
mtimer_top.sv
tb_mtimer_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f mtimer_top.f --top-module tb_mtimer_top -o sim

out=$(./obj_dir/sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
